/* hdl/mips_pkg.sv */
`default_nettype none

package mips_pkg;

    typedef logic [31:0] word_t;    // data or address word.
    typedef logic [4:0]  reg_idx_t; // register index.

    // primary opcodes kept in the subset.
    typedef enum logic [5:0] {
        op_special = 6'h00,
        op_beq     = 6'h04,
        op_bne     = 6'h05,
        op_blez    = 6'h06,
        op_bgtz    = 6'h07,
        op_addiu   = 6'h09,
        op_andi    = 6'h0c,
        op_ori     = 6'h0d,
        op_lui     = 6'h0f,
        op_lw      = 6'h23,
        op_sw      = 6'h2b
    } opcode_t;

    // r-type function codes.
    typedef enum logic [5:0] {
        fn_jr   = 6'h08,
        fn_addu = 6'h21,
        fn_subu = 6'h23,
        fn_and  = 6'h24,
        fn_or   = 6'h25,
        fn_slt  = 6'h2a
    } funct_t;

    typedef enum logic [2:0] {alu_add, alu_sub, alu_and, alu_or, alu_slt, alu_lui} alu_op_t;

    typedef enum logic [2:0] {br_none, br_eq, br_ne, br_lez, br_gtz} branch_cond_t;

    typedef enum logic [2:0] {
        s_idle, s_fetch, s_decode, s_execute, s_memory, s_writeback, s_halted
    } seq_state_t;

    localparam reg_idx_t reg_v0 = 5'd2; // result register seen at the top.

endpackage

`default_nettype wire

/* hdl/avalon_bus_master.sv */
`timescale 1ns/10ps
`default_nettype none

module avalon_bus_master import mips_pkg::*; (
    input  wire logic  clk,
    input  wire logic  rst_n,
    input  wire logic  req_read,
    input  wire logic  req_write,
    input  wire word_t req_addr,
    input  wire word_t req_wdata,
    output logic       done,
    output word_t      rdata,
    output word_t      address,
    output logic       read,
    output logic       write,
    output word_t      writedata,
    output logic [3:0] byteenable,
    input  wire logic  waitrequest,
    input  wire word_t readdata
);

    assign byteenable = 4'b1111; // word accesses only.

    // transfer ends on the first edge with waitrequest low.
    assign done  = (read || write) && !waitrequest;
    assign rdata = readdata;      // valid while done is high.

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            read  <= 1'b0;
            write <= 1'b0;
        end else if (req_read || req_write) begin
            read  <= req_read;
            write <= req_write;
        end else if (done) begin
            read  <= 1'b0;
            write <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (req_read || req_write) begin
            address   <= req_addr;
            writedata <= req_wdata;
        end
    end

    // ************************************************************************
    // bus protocol checks.
    // ************************************************************************
    a_hold_stable : assert property (@(posedge clk) disable iff (!rst_n)
        (read || write) && waitrequest |=> $stable(address) && $stable(writedata)
            && $stable(read) && $stable(write))
        else $error("address or command changed during waitrequest.");

    a_no_read_write : assert property (@(posedge clk) disable iff (!rst_n)
        !(read && write))
        else $error("read and write asserted together.");

endmodule

`default_nettype wire

/* hdl/alu_branch_unit.sv */
`timescale 1ns/10ps
`default_nettype none

module alu_branch_unit import mips_pkg::*; (
    input  wire alu_op_t      alu_op,
    input  wire word_t        operand_a,
    input  wire word_t        operand_b,
    input  wire branch_cond_t branch_cond,
    output word_t             result,
    output logic              taken
);

    logic a_zero; // shared by the lez and gtz tests.
    logic a_neg;

    assign a_zero = (operand_a == '0);
    assign a_neg  = operand_a[31];

    always_comb begin
        case (alu_op)
            alu_add: result = operand_a + operand_b; // wraps, no overflow trap.
            alu_sub: result = operand_a - operand_b;
            alu_and: result = operand_a & operand_b;
            alu_or:  result = operand_a | operand_b;
            alu_slt: begin
                result = {31'b0, ($signed(operand_a) < $signed(operand_b))};
            end
            alu_lui: result = {operand_b[15:0], 16'h0000};
            default: result = '0;
        endcase
    end

    // branch tests.
    always_comb begin
        case (branch_cond)
            br_eq:   taken = (operand_a == operand_b);
            br_ne:   taken = (operand_a != operand_b);
            br_lez:  taken = a_neg || a_zero;      // signed <= 0.
            br_gtz:  taken = !a_neg && !a_zero;
            default: taken = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

/* hdl/reg_file.sv */
`timescale 1ns/10ps
`default_nettype none

module reg_file import mips_pkg::*; (
    input  wire logic     clk,
    input  wire logic     rst_n,
    input  wire reg_idx_t rs_idx,
    input  wire reg_idx_t rt_idx,
    output word_t         rs_data,
    output word_t         rt_data,
    input  wire logic     wr_en,
    input  wire reg_idx_t wr_idx,
    input  wire word_t    wr_data,
    output word_t         register_v0
);

    word_t regs [1:31]; // $0 has no storage.

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && (wr_idx != '0)) begin
            regs[wr_idx] <= wr_data;
        end
    end

    assign rs_data     = (rs_idx == '0) ? '0 : regs[rs_idx];
    assign rt_data     = (rt_idx == '0) ? '0 : regs[rt_idx];
    assign register_v0 = regs[reg_v0];

    a_wr_idx_known : assert property (@(posedge clk) disable iff (!rst_n)
        wr_en |-> !$isunknown(wr_idx))
        else $error("register write with unknown index.");

endmodule

`default_nettype wire

/* hdl/cpu_sequencer.sv */
`timescale 1ns/10ps
`default_nettype none

module cpu_sequencer import mips_pkg::*; #(
    parameter word_t reset_vector = 32'h0000_0004
) (
    input  wire logic     clk,
    input  wire logic     rst_n,
    output logic          active,
    output logic          req_read,
    output logic          req_write,
    output word_t         req_addr,
    output word_t         req_wdata,
    input  wire logic     done,
    input  wire word_t    rdata,
    output alu_op_t       alu_op,
    output word_t         operand_a,
    output word_t         operand_b,
    output branch_cond_t  branch_cond,
    input  wire word_t    result,
    input  wire logic     taken,
    output reg_idx_t      rs_idx,
    output reg_idx_t      rt_idx,
    input  wire word_t    rs_data,
    input  wire word_t    rt_data,
    output logic          wr_en,
    output reg_idx_t      wr_idx,
    output word_t         wr_data
);

    seq_state_t   state;
    word_t        pc, ir, next_pc;
    word_t        imm_q, result_q, br_target_q, pend_target;
    reg_idx_t     dest_q;
    alu_op_t      alu_op_q;
    branch_cond_t cond_q;
    logic         use_imm_q, reg_write_q, load_q, store_q, jr_q;
    logic         br_taken_q, pend_valid, halting;

    // decoded fields of ir.
    alu_op_t      dec_alu_op;
    branch_cond_t dec_cond;
    word_t        dec_imm;
    reg_idx_t     dec_dest;
    logic         dec_use_imm, dec_wr, dec_load, dec_store, dec_jr;

    // ************************************************************************
    // instruction decode.
    // ************************************************************************
    always_comb begin
        dec_alu_op  = alu_add;
        dec_cond    = br_none;
        dec_imm     = {{16{ir[15]}}, ir[15:0]}; // sign extended by default.
        dec_dest    = ir[20:16];
        dec_use_imm = 1'b1;
        dec_wr      = 1'b0;
        dec_load    = 1'b0;
        dec_store   = 1'b0;
        dec_jr      = 1'b0;
        case (opcode_t'(ir[31:26]))
            op_special: begin
                dec_use_imm = 1'b0;
                dec_dest    = ir[15:11];
                case (funct_t'(ir[5:0]))
                    fn_addu: dec_wr = 1'b1;
                    fn_subu: begin dec_alu_op = alu_sub; dec_wr = 1'b1; end
                    fn_and:  begin dec_alu_op = alu_and; dec_wr = 1'b1; end
                    fn_or:   begin dec_alu_op = alu_or;  dec_wr = 1'b1; end
                    fn_slt:  begin dec_alu_op = alu_slt; dec_wr = 1'b1; end
                    fn_jr:   dec_jr = 1'b1;
                    default: ; // no-op.
                endcase
            end
            op_addiu: dec_wr = 1'b1;
            op_andi: begin
                dec_alu_op = alu_and;
                dec_imm    = {16'h0000, ir[15:0]};
                dec_wr     = 1'b1;
            end
            op_ori: begin
                dec_alu_op = alu_or;
                dec_imm    = {16'h0000, ir[15:0]};
                dec_wr     = 1'b1;
            end
            op_lui: begin dec_alu_op = alu_lui; dec_wr = 1'b1; end
            op_lw:  begin dec_load = 1'b1; dec_wr = 1'b1; end
            op_sw:  dec_store = 1'b1;
            // branches compare rs with rt, imm kept for the target.
            op_beq:  begin dec_cond = br_eq;  dec_use_imm = 1'b0; end
            op_bne:  begin dec_cond = br_ne;  dec_use_imm = 1'b0; end
            op_blez: begin dec_cond = br_lez; dec_use_imm = 1'b0; end
            op_bgtz: begin dec_cond = br_gtz; dec_use_imm = 1'b0; end
            default: ; // unknown opcode runs as a no-op.
        endcase
    end

    assign rs_idx      = ir[25:21];
    assign rt_idx      = ir[20:16];
    assign alu_op      = alu_op_q;
    assign branch_cond = cond_q;
    assign operand_a   = rs_data;
    assign operand_b   = use_imm_q ? imm_q : rt_data;

    assign next_pc = pend_valid ? pend_target : pc + 32'd4; // delay slot resolves here.
    assign halting = pend_valid && (pend_target == '0);     // jr $0 delay slot done.

    assign wr_en   = (state == s_writeback) && reg_write_q;
    assign wr_idx  = dest_q;
    assign wr_data = result_q;

    // bus requests are single-cycle pulses on entry to fetch or memory.
    always_comb begin
        req_read  = 1'b0;
        req_write = 1'b0;
        req_addr  = next_pc;
        req_wdata = rt_data;
        case (state)
            s_idle: begin
                req_read = 1'b1;
                req_addr = pc;
            end
            s_execute: begin
                req_read  = load_q;
                req_write = store_q;
                req_addr  = result; // rs + offset.
            end
            s_writeback: req_read = !halting;
            default: ;
        endcase
    end

    // ************************************************************************
    // state machine and control registers.
    // ************************************************************************
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state       <= s_idle;
            pc          <= reset_vector;
            active      <= 1'b0;
            pend_valid  <= 1'b0;
            br_taken_q  <= 1'b0;
            alu_op_q    <= alu_add;
            cond_q      <= br_none;
            use_imm_q   <= 1'b0;
            reg_write_q <= 1'b0;
            load_q      <= 1'b0;
            store_q     <= 1'b0;
            jr_q        <= 1'b0;
        end else begin
            case (state)
                s_idle: begin
                    state  <= s_fetch;
                    active <= 1'b1;
                end
                s_fetch: if (done) state <= s_decode;
                s_decode: begin
                    alu_op_q    <= dec_alu_op;
                    cond_q      <= dec_cond;
                    use_imm_q   <= dec_use_imm;
                    reg_write_q <= dec_wr;
                    load_q      <= dec_load;
                    store_q     <= dec_store;
                    jr_q        <= dec_jr;
                    state       <= s_execute;
                end
                s_execute: begin
                    br_taken_q <= jr_q || taken;
                    state      <= (load_q || store_q) ? s_memory : s_writeback;
                end
                s_memory: if (done) state <= s_writeback;
                s_writeback: begin
                    pc         <= next_pc;
                    pend_valid <= br_taken_q; // arm after this instruction.
                    if (halting) begin
                        state  <= s_halted;
                        active <= 1'b0;
                    end else begin
                        state  <= s_fetch;
                    end
                end
                default: state <= s_halted; // stays here until reset.
            endcase
        end
    end

    // payload registers.
    always_ff @(posedge clk) begin
        if (state == s_fetch && done) begin
            ir <= rdata;
        end
        if (state == s_decode) begin
            imm_q  <= dec_imm;
            dest_q <= dec_dest;
        end
        if (state == s_execute) begin
            result_q    <= result;
            br_target_q <= jr_q ? rs_data : pc + 32'd4 + {imm_q[29:0], 2'b00};
        end
        if (state == s_memory && done && load_q) begin
            result_q <= rdata;
        end
        if (state == s_writeback) begin
            pend_target <= br_target_q;
        end
    end

    a_fetch_aligned : assert property (@(posedge clk) disable iff (!rst_n)
        (state == s_fetch) |-> (pc[1:0] == 2'b00))
        else $error("fetch from an unaligned address.");

endmodule

`default_nettype wire

/* hdl/mips_cpu_top.sv */
`timescale 1ns/10ps
`default_nettype none

module mips_cpu_top import mips_pkg::*; #(
    parameter word_t reset_vector = 32'h0000_0004
) (
    input  wire logic  clk,
    input  wire logic  rst_n,
    output logic       active,
    output word_t      register_v0,
    output word_t      address,
    output logic       write,
    output logic       read,
    input  wire logic  waitrequest,
    output word_t      writedata,
    output logic [3:0] byteenable,
    input  wire word_t readdata
);

    // sequencer to bus master.
    logic  req_read, req_write, done;
    word_t req_addr, req_wdata, rdata;

    // sequencer to alu.
    alu_op_t      alu_op;
    branch_cond_t branch_cond;
    word_t        operand_a, operand_b, result;
    logic         taken;

    // sequencer to register file.
    reg_idx_t rs_idx, rt_idx, wr_idx;
    word_t    rs_data, rt_data, wr_data;
    logic     wr_en;

    avalon_bus_master u_bus (
        .clk, .rst_n,
        .req_read, .req_write, .req_addr, .req_wdata,
        .done, .rdata,
        .address, .read, .write, .writedata, .byteenable,
        .waitrequest, .readdata
    );

    cpu_sequencer #(.reset_vector(reset_vector)) u_seq (
        .clk, .rst_n, .active,
        .req_read, .req_write, .req_addr, .req_wdata, .done, .rdata,
        .alu_op, .operand_a, .operand_b, .branch_cond, .result, .taken,
        .rs_idx, .rt_idx, .rs_data, .rt_data, .wr_en, .wr_idx, .wr_data
    );

    alu_branch_unit u_alu (
        .alu_op, .operand_a, .operand_b, .branch_cond, .result, .taken
    );

    reg_file u_regs (
        .clk, .rst_n,
        .rs_idx, .rt_idx, .rs_data, .rt_data,
        .wr_en, .wr_idx, .wr_data,
        .register_v0
    );

endmodule

`default_nettype wire

/* sim/clock_gen.sv */
`timescale 1ns/10ps
`default_nettype none

module clock_gen (
    output logic clk
);

    localparam int half_period = 4; // 8 ns period.

    initial clk = 1'b0;

    always #(half_period) clk = ~clk;

endmodule

`default_nettype wire

/* sim/avalon_ram_model.sv */
`timescale 1ns/10ps
`default_nettype none

module avalon_ram_model import mips_pkg::*; (
    input  wire logic       clk,
    input  wire logic       rst_n,
    input  wire word_t      address,
    input  wire logic       read,
    input  wire logic       write,
    input  wire word_t      writedata,
    input  wire logic [3:0] byteenable,
    output logic            waitrequest,
    output word_t           readdata
);

    localparam int depth = 1024; // 4 kbyte, word addressed.

    word_t       mem [depth];
    int unsigned stall_tab [256]; // stall lengths, replayed one per transfer.
    logic [7:0]  stall_ptr;
    int unsigned stall_cnt;

    assign readdata = mem[address[11:2]]; // valid on the edge with waitrequest low.

    // ************************************************************************
    // backdoor access.
    // ************************************************************************
    task automatic clear_memory();
        for (int i = 0; i < depth; i++) begin
            mem[i] <= {6'h3f, 16'h0000, i[9:0]}; // opcode 3f decodes as a no-op.
        end
    endtask

    task automatic load_word(input word_t addr, input word_t data);
        mem[addr[11:2]] <= data;
    endtask

    // stall lengths of 0 to max_stall cycles.
    task automatic set_max_stall(input int unsigned max_stall);
        foreach (stall_tab[i]) begin
            stall_tab[i] = (max_stall == 0) ? 0 : $urandom % (max_stall + 1);
        end
    endtask

    // ************************************************************************
    // slave side.
    // ************************************************************************
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            waitrequest <= 1'b0;
            stall_cnt   <= 0;
            stall_ptr   <= '0;
        end else if (read || write) begin
            if (!waitrequest) begin
                if (write) begin
                    for (int b = 0; b < 4; b++) begin
                        if (byteenable[b]) begin
                            mem[address[11:2]][8*b +: 8] <= writedata[8*b +: 8];
                        end
                    end
                end
                // arm the stall of the next transfer.
                stall_cnt   <= stall_tab[stall_ptr];
                waitrequest <= (stall_tab[stall_ptr] != 0);
                stall_ptr   <= stall_ptr + 8'd1;
            end else begin
                stall_cnt   <= stall_cnt - 1;
                waitrequest <= (stall_cnt > 1);
            end
        end
    end

endmodule

`default_nettype wire

/* sim/tb_mips_cpu.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_mips_cpu import mips_pkg::*; ();

    localparam int tests_total = 6;
    localparam int run_limit   = 2000; // cycles per program.
    localparam int watchdog_ns = tests_total * run_limit * 8;

    logic       clk, rst_n, waitrequest, active, read, write;
    word_t      register_v0, address, writedata, readdata;
    logic [3:0] byteenable;

    int    errors = 0;
    int    runs = 0;
    word_t prog [$];
    word_t wr_addr_q [$];
    word_t wr_data_q [$];
    logic  hold_pending = 1'b0;
    word_t hold_addr, hold_wdata;

    clock_gen u_clk (.clk);

    mips_cpu_top #(.reset_vector(32'h0000_0004)) dut (
        .clk, .rst_n, .active, .register_v0,
        .address, .write, .read, .waitrequest, .writedata, .byteenable, .readdata
    );

    avalon_ram_model ram (
        .clk, .rst_n, .address, .read, .write, .writedata, .byteenable,
        .waitrequest, .readdata
    );

    task automatic report_mismatch(input string name, input word_t got, input word_t exp);
        errors++;
        $display("FAILED at %0t: %s is %h, expected %h", $time, name, got, exp);
    endtask

    function automatic word_t encode_imm(logic [5:0] op, reg_idx_t rs, reg_idx_t rt,
                                         logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic word_t encode_reg(reg_idx_t rs, reg_idx_t rt, reg_idx_t rd,
                                         logic [5:0] fn);
        return {6'h00, rs, rt, rd, 5'd0, fn};
    endfunction

    // ************************************************************************
    // reset, load prog at the reset vector, run until active falls.
    // ************************************************************************
    task automatic run_program(input int max_stall);
        int cycles;
        @(posedge clk);
        rst_n <= 1'b0;
        wr_addr_q.delete();
        wr_data_q.delete();
        ram.clear_memory();
        foreach (prog[i]) ram.load_word(32'h4 + 4 * i, prog[i]);
        ram.set_max_stall(max_stall);
        repeat (8) begin
            @(posedge clk);
            if (active || read || write) begin
                errors++;
                $display("active, read or write is high during reset at %0t", $time);
            end
        end
        rst_n <= 1'b1;
        runs++;
        cycles = 0;
        do begin
            @(posedge clk);
            cycles++;
        end while ((active || cycles < 3) && cycles < run_limit);
        if (cycles >= run_limit) begin
            errors++;
            $display("program %0d did not halt within %0d cycles", runs, run_limit);
        end
    endtask

    // v0 = 10 + 20 + 40, plus 30 when the branch falls through.
    task automatic test_branch(input opcode_t op, input int v1, input int a0, input int stall);
        logic     taken;
        reg_idx_t rt;
        word_t    expected;
        case (op)
            op_beq:  taken = (v1 == a0);
            op_bne:  taken = (v1 != a0);
            op_blez: taken = (v1 <= 0);
            default: taken = (v1 > 0);
        endcase
        rt       = (op == op_beq || op == op_bne) ? 5'd4 : 5'd0;
        expected = taken ? 32'h70 : 32'ha0;
        prog.delete();
        prog.push_back(encode_imm(op_addiu, 0, 2, 16'h0010));
        prog.push_back(encode_imm(op_addiu, 0, 3, v1[15:0]));
        prog.push_back(encode_imm(op_addiu, 0, 4, a0[15:0]));
        prog.push_back(encode_imm(op, 3, rt, 16'd2));          // skips one add.
        prog.push_back(encode_imm(op_addiu, 2, 2, 16'h0020));  // delay slot.
        prog.push_back(encode_imm(op_addiu, 2, 2, 16'h0030));
        prog.push_back(encode_imm(op_addiu, 2, 2, 16'h0040));
        prog.push_back(encode_reg(0, 0, 0, fn_jr));
        prog.push_back(32'h0000_0000);
        run_program(stall);
        if (register_v0 !== expected) report_mismatch("register_v0", register_v0, expected);
    endtask

    task automatic test_alu(input word_t a, input word_t b, input int stall);
        word_t expected;
        expected = a + 32'hffff_fed4;            // addiu -300.
        expected = expected + (a & 32'h0000_8f0f); // andi, zero extended.
        expected = expected - (a + b) + (a - b) + (a & b) - (a | b);
        if ($signed(a) < $signed(b)) expected = expected + 1;
        if ($signed(b) < $signed(a)) expected = expected + 2;
        prog.delete();
        prog.push_back(encode_imm(op_lui, 0, 8, a[31:16]));
        prog.push_back(encode_imm(op_ori, 8, 8, a[15:0]));
        prog.push_back(encode_imm(op_lui, 0, 9, b[31:16]));
        prog.push_back(encode_imm(op_ori, 9, 9, b[15:0]));
        prog.push_back(encode_imm(op_addiu, 8, 10, 16'hfed4));
        prog.push_back(encode_imm(op_andi, 8, 11, 16'h8f0f));
        prog.push_back(encode_reg(10, 11, 2, fn_addu));
        prog.push_back(encode_reg(8, 9, 12, fn_addu));
        prog.push_back(encode_reg(2, 12, 2, fn_subu));
        prog.push_back(encode_reg(8, 9, 12, fn_subu));
        prog.push_back(encode_reg(2, 12, 2, fn_addu));
        prog.push_back(encode_reg(8, 9, 12, fn_and));
        prog.push_back(encode_reg(2, 12, 2, fn_addu));
        prog.push_back(encode_reg(8, 9, 12, fn_or));
        prog.push_back(encode_reg(2, 12, 2, fn_subu));
        prog.push_back(encode_reg(8, 9, 12, fn_slt));
        prog.push_back(encode_reg(2, 12, 2, fn_addu));
        prog.push_back(encode_reg(9, 8, 12, fn_slt));
        prog.push_back(encode_reg(2, 12, 2, fn_addu));
        prog.push_back(encode_reg(2, 12, 2, fn_addu));
        prog.push_back(encode_reg(0, 0, 0, fn_jr));
        prog.push_back(32'h0000_0000);
        run_program(stall);
        if (register_v0 !== expected) report_mismatch("register_v0", register_v0, expected);
    endtask

    task automatic test_load_store(input word_t d, input int stall);
        prog.delete();
        prog.push_back(encode_imm(op_lui, 0, 8, d[31:16]));
        prog.push_back(encode_imm(op_ori, 8, 8, d[15:0]));
        prog.push_back(encode_imm(op_addiu, 0, 9, 16'h0200));
        prog.push_back(encode_imm(op_sw, 9, 8, 16'h0008));   // 0x208.
        prog.push_back(encode_imm(op_addiu, 8, 10, 16'h0001));
        prog.push_back(encode_imm(op_sw, 9, 10, 16'hfffc));  // 0x1fc.
        prog.push_back(encode_imm(op_lw, 9, 2, 16'h0008));
        prog.push_back(encode_reg(0, 0, 0, fn_jr));
        prog.push_back(32'h0000_0000);
        run_program(stall);
        if (wr_addr_q.size() != 2) begin
            errors++;
            $display("expected 2 bus writes, saw %0d", wr_addr_q.size());
        end else begin
            if (wr_addr_q[0] !== 32'h208) report_mismatch("address", wr_addr_q[0], 32'h208);
            if (wr_data_q[0] !== d) report_mismatch("writedata", wr_data_q[0], d);
            if (wr_addr_q[1] !== 32'h1fc) report_mismatch("address", wr_addr_q[1], 32'h1fc);
            if (wr_data_q[1] !== d + 1) report_mismatch("writedata", wr_data_q[1], d + 1);
        end
        if (register_v0 !== d) report_mismatch("register_v0", register_v0, d);
    endtask

    // the jr delay slot runs, the word after it does not.
    task automatic test_reset_halt();
        // restart the last program so that the next reset hits a busy CPU.
        @(posedge clk);
        rst_n <= 1'b0;
        @(posedge clk);
        rst_n <= 1'b1;
        repeat (3) @(posedge clk);
        prog.delete();
        prog.push_back(encode_imm(op_addiu, 0, 2, 16'h0055));
        prog.push_back(encode_reg(0, 0, 0, fn_jr));
        prog.push_back(encode_imm(op_addiu, 2, 2, 16'h0100));
        prog.push_back(encode_imm(op_addiu, 2, 2, 16'h0200));
        run_program(0);
        if (register_v0 !== 32'h155) report_mismatch("register_v0", register_v0, 32'h155);
        repeat (50) begin
            @(posedge clk);
            if (active || read || write) begin
                errors++;
                $display("CPU not idle after halt at %0t", $time);
            end
        end
    endtask

    task automatic test_reg_zero();
        prog.delete();
        prog.push_back(encode_imm(op_addiu, 0, 2, 16'h0033));
        prog.push_back(encode_imm(op_addiu, 0, 0, 16'h0077));
        prog.push_back(encode_reg(2, 0, 2, fn_addu));
        prog.push_back(encode_reg(0, 0, 0, fn_jr));
        prog.push_back(32'h0000_0000);
        run_program(0);
        if (register_v0 !== 32'h33) report_mismatch("register_v0", register_v0, 32'h33);
    endtask

    // bus monitor.
    always @(posedge clk) begin
        if (hold_pending && address !== hold_addr) begin
            report_mismatch("address", address, hold_addr);
        end
        if (hold_pending && writedata !== hold_wdata) begin
            report_mismatch("writedata", writedata, hold_wdata);
        end
        hold_pending <= rst_n && (read || write) && waitrequest;
        hold_addr    <= address;
        hold_wdata   <= writedata;
        if (rst_n && write && !waitrequest) begin
            wr_addr_q.push_back(address);
            wr_data_q.push_back(writedata);
            if (byteenable !== 4'hf) report_mismatch("byteenable", {28'h0, byteenable}, 32'hf);
        end
    end

    initial begin
        word_t a, b, d;
        int    stall;
        rst_n = 1'b0;
        ram.clear_memory();
        void'($urandom(21484));
        a = $urandom | 32'h0000_8000; // ori with bit 15 set.
        b = $urandom;
        d = $urandom;
        for (int pass = 0; pass < 2; pass++) begin
            stall = pass * 3; // second pass under back-pressure.
            test_branch(op_blez, -5, 0, stall);
            test_branch(op_blez, 0, 0, stall);
            test_branch(op_blez, 7, 0, stall);
            test_branch(op_bgtz, 7, 0, stall);
            test_branch(op_bgtz, 0, 0, stall);
            test_branch(op_bgtz, -3, 0, stall);
            test_branch(op_beq, 5, 5, stall);
            test_branch(op_beq, 5, 6, stall);
            test_branch(op_bne, 5, 6, stall);
            test_branch(op_bne, 5, 5, stall);
            test_alu(a, b, stall);
            test_load_store(d, stall);
        end
        test_reset_halt();
        test_reg_zero();
        $display("programs run: %0d, errors: %0d", runs, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    initial begin
        #(watchdog_ns);
        $display("timeout, the tests did not finish within %0d ns", watchdog_ns);
        $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* verilog.f */
hdl/mips_pkg.sv
hdl/avalon_bus_master.sv
hdl/alu_branch_unit.sv
hdl/reg_file.sv
hdl/cpu_sequencer.sv
hdl/mips_cpu_top.sv
sim/clock_gen.sv
sim/avalon_ram_model.sv
sim/tb_mips_cpu.sv
